// ==== all.f ====
+incdir+rtl
rtl/ncpu_pkg.sv
rtl/ex_alu.sv
rtl/ex_bru.sv
rtl/ex_lane_ctrl.sv
rtl/ex_lane.sv
rtl/ex.sv
bench/ex_properties.sv
bench/ex_tb.sv

// ==== bench/ex_properties.sv ====
// Execute stage assertions
`timescale 1ns/1ps
`include "ncpu_config.svh"

module ex_properties
(
   input logic clk,
   input logic arst_n,
   input logic flush,
   input logic [`NCPU_IW-1:0] ex_valid,
   input ncpu_pkg::ex_uop_t [`NCPU_IW-1:0] ex_uop,
   input logic [`NCPU_IW-1:0] ex_ready,
   input logic [`NCPU_IW-1:0] wb_valid,
   input ncpu_pkg::ex_wb_t [`NCPU_IW-1:0] wb,
   input logic [`NCPU_IW-1:0] wb_ready
);
   import ncpu_pkg::*;

   int unsigned fail_cnt = 0; // Read by the testbench

   // Reference model of one micro-op
   function automatic ex_wb_t model_wb(input ex_uop_t u);
      ex_wb_t r;
      data_t b;
      data_t nxt_pc;
      data_t tgt;
      logic tk;
      b = u.use_imm ? u.imm : u.operand2;
      nxt_pc = u.pc + 32'd4;
      tgt = u.pc + u.imm;
      r.rob_id = u.rob_id;
      r.rob_bank = u.rob_bank;
      r.prf_we = u.prd_we;
      r.prf_waddr = u.prd;
      r.opera = u.operand1;
      r.operb = u.operand2;
      case (u.alu_opc)
         ALU_ADD: r.prf_wdata = u.operand1 + b;
         ALU_SUB: r.prf_wdata = u.operand1 - b;
         ALU_AND: r.prf_wdata = u.operand1 & b;
         ALU_OR: r.prf_wdata = u.operand1 | b;
         ALU_XOR: r.prf_wdata = u.operand1 ^ b;
         ALU_SLL: r.prf_wdata = u.operand1 << b[4:0];
         ALU_SRL: r.prf_wdata = u.operand1 >> b[4:0];
         ALU_SRA: r.prf_wdata = `NCPU_ENABLE_ASR ? data_t'($signed(u.operand1) >>> b[4:0])
                                                 : u.operand1 >> b[4:0];
         ALU_SLT: r.prf_wdata = ($signed(u.operand1) < $signed(b)) ? 32'd1 : 32'd0;
         ALU_SLTU: r.prf_wdata = (u.operand1 < b) ? 32'd1 : 32'd0;
         default: r.prf_wdata = '0;
      endcase
      case (u.bru_opc)
         BRU_BEQ: tk = (u.operand1 == u.operand2);
         BRU_BNE: tk = (u.operand1 != u.operand2);
         BRU_BLT: tk = ($signed(u.operand1) < $signed(u.operand2));
         BRU_BGE: tk = ($signed(u.operand1) >= $signed(u.operand2));
         BRU_JAL: tk = 1'b1;
         default: tk = 1'b0;
      endcase
      r.fls = 1'b0;
      r.fls_tgt = tk ? tgt : nxt_pc;
      if (u.bru_opc != BRU_NONE)
      begin
         r.prf_wdata = nxt_pc; // Link value
         r.fls = (tk != u.pred_taken) || (tk && (u.pred_tgt != tgt));
      end
      return r;
   endfunction

   genvar i;

   generate
      for (i = 0; i < `NCPU_IW; i = i + 1)
      begin : gen_chk
         ex_wb_t exp_r; // Expected record of this lane

         always_ff @(posedge clk)
         begin
            if (ex_valid[i] && ex_ready[i])
            begin
               exp_r <= model_wb(ex_uop[i]); // Accepted uop
            end
         end

         a_latency: assert property (@(posedge clk) disable iff (!arst_n)
            (ex_valid[i] && ex_ready[i]) |=> wb_valid[i])
            else begin fail_cnt++; $error("FAIL %0t lane %0d no result after accept", $time, i); end

         a_data: assert property (@(posedge clk) disable iff (!arst_n)
            wb_valid[i] |-> (wb[i] == exp_r))
            else begin fail_cnt++; $error("FAIL %0t lane %0d wrong write-back record", $time, i); end

         a_stall: assert property (@(posedge clk) disable iff (!arst_n)
            (wb_valid[i] && !wb_ready[i]) |-> !ex_ready[i])
            else begin fail_cnt++; $error("FAIL %0t lane %0d ready while stalled", $time, i); end

         // Empty or draining lane takes a new uop
         a_ready: assert property (@(posedge clk) disable iff (!arst_n)
            (!flush && (!wb_valid[i] || wb_ready[i])) |-> ex_ready[i])
            else begin fail_cnt++; $error("FAIL %0t lane %0d not ready while free", $time, i); end

         a_hold: assert property (@(posedge clk) disable iff (!arst_n)
            (wb_valid[i] && !wb_ready[i] && !flush) |=> (wb_valid[i] && $stable(wb[i])))
            else begin fail_cnt++; $error("FAIL %0t lane %0d record not held", $time, i); end
      end
   endgenerate

   a_flush_rdy: assert property (@(posedge clk) disable iff (!arst_n)
      flush |-> (ex_ready == '0))
      else begin fail_cnt++; $error("FAIL %0t ready during flush", $time); end

   a_flush_clr: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> (wb_valid == '0))
      else begin fail_cnt++; $error("FAIL %0t valid after flush", $time); end

   // Reset checks stay live while arst_n is low
   a_rst_idle: assert property (@(posedge clk) !arst_n |-> (wb_valid == '0))
      else begin fail_cnt++; $error("FAIL %0t valid during reset", $time); end

   a_rst_rel: assert property (@(posedge clk) $rose(arst_n) |-> (wb_valid == '0))
      else begin fail_cnt++; $error("FAIL %0t valid after reset release", $time); end

endmodule

bind ex ex_properties u_props (.*);

// ==== bench/ex_tb.sv ====
// Execute stage testbench
`timescale 1ns/1ps
`include "ncpu_config.svh"

module ex_tb;
   import ncpu_pkg::*;

   localparam int MAX_CYCLES = 3000; // 2000 random cycles plus margin

   logic clk;
   logic arst_n;
   logic flush;
   logic [`NCPU_IW-1:0] ex_valid;
   ex_uop_t [`NCPU_IW-1:0] ex_uop;
   logic [`NCPU_IW-1:0] ex_ready;
   logic [`NCPU_IW-1:0] wb_valid;
   ex_wb_t [`NCPU_IW-1:0] wb;
   logic [`NCPU_IW-1:0] wb_ready;

   integer seed;
   int unsigned errors = 0;
   int unsigned cycles = 0;
   int unsigned n_acc [`NCPU_IW]; // Accepted per lane
   int unsigned n_done [`NCPU_IW]; // Consumed or flushed per lane

   ex u_ex
   (
      .clk (clk),
      .arst_n (arst_n),
      .flush (flush),
      .ex_valid (ex_valid),
      .ex_uop (ex_uop),
      .ex_ready (ex_ready),
      .wb_valid (wb_valid),
      .wb (wb),
      .wb_ready (wb_ready)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   // Random micro-op, branch operands often equal
   task automatic make_rand_uop(output ex_uop_t u);
      u = ex_uop_t'(0);
      u.pc = {$random(seed)} & 32'hffff_fffc;
      u.operand1 = $random(seed);
      u.operand2 = ($random(seed) & 3) == 0 ? u.operand1 : $random(seed);
      u.imm = $random(seed);
      u.use_imm = 1'($random(seed));
      u.alu_opc = alu_opc_t'({$random(seed)} % 10);
      u.bru_opc = ($random(seed) & 1) ? bru_opc_t'({$random(seed)} % 6) : BRU_NONE;
      u.pred_taken = 1'($random(seed));
      u.pred_tgt = ($random(seed) & 1) ? u.pc + u.imm : $random(seed);
      u.prd = prf_addr_t'($random(seed));
      u.prd_we = 1'($random(seed));
      u.rob_id = rob_id_t'($random(seed));
      u.rob_bank = rob_bank_t'($random(seed));
   endtask

   // Handshake bookkeeping
   always @(posedge clk)
   begin
      if (arst_n)
      begin
         for (int l = 0; l < `NCPU_IW; l++)
         begin
            if (flush && wb_valid[l])
               n_done[l]++; // Discarded
            else if (!flush && wb_valid[l] && wb_ready[l])
               n_done[l]++;
            if (ex_valid[l] && ex_ready[l])
               n_acc[l]++;
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= MAX_CYCLES)
      begin
         $display("Timeout after %0d cycles, stimulus did not finish", cycles);
         $display("** FAIL **");
         $finish;
      end
   end

   initial
   begin
      ex_uop_t u;
      seed = 32'h182e6c64;
      arst_n = 1'b0;
      flush = 1'b0;
      ex_valid = '0;
      ex_uop = '0;
      wb_ready = '0;
      for (int l = 0; l < `NCPU_IW; l++)
      begin
         n_acc[l] = 0;
         n_done[l] = 0;
      end
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // Every ALU opcode, register and imm forms
      for (int op = 0; op < 10; op++)
      begin
         for (int k = 0; k < 2; k++)
         begin
            @(negedge clk);
            wb_ready = '1;
            ex_valid = '1;
            for (int l = 0; l < `NCPU_IW; l++)
            begin
               make_rand_uop(u);
               u.alu_opc = alu_opc_t'(op);
               u.bru_opc = BRU_NONE;
               u.use_imm = k[0];
               ex_uop[l] = u;
            end
         end
      end

      // Every branch with both outcomes and both predictions
      for (int op = 1; op < 6; op++)
      begin
         for (int k = 0; k < 4; k++)
         begin
            @(negedge clk);
            for (int l = 0; l < `NCPU_IW; l++)
            begin
               make_rand_uop(u);
               u.bru_opc = bru_opc_t'(op);
               u.operand2 = k[0] ? u.operand1 : ~u.operand1;
               u.pred_taken = k[1];
               u.pred_tgt = (l == 0) ? u.pc + u.imm : u.pc + u.imm + 32'd8;
               ex_uop[l] = u;
            end
         end
      end

      // Random traffic with stalls and flushes
      repeat (2000)
      begin
         @(negedge clk);
         flush = ({$random(seed)} % 40) == 0;
         for (int l = 0; l < `NCPU_IW; l++)
         begin
            ex_valid[l] = 1'($random(seed));
            wb_ready[l] = 1'($random(seed));
            make_rand_uop(u);
            ex_uop[l] = u;
         end
      end

      // Drain
      @(negedge clk);
      flush = 1'b0;
      ex_valid = '0;
      wb_ready = '1;
      repeat (4) @(negedge clk);

      for (int l = 0; l < `NCPU_IW; l++)
      begin
         if (n_acc[l] != n_done[l] || wb_valid[l])
         begin
            errors++;
            $display("FAIL %0t lane %0d accepted %0d, retired %0d", $time, l,
                     n_acc[l], n_done[l]);
         end
      end

      $display("Errors: %0d testbench, %0d assertion", errors, u_ex.u_props.fail_cnt);
      if (errors == 0 && u_ex.u_props.fail_cnt == 0)
      begin
         $display("** PASS **");
      end
      else
      begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// ==== rtl/ex.sv ====
// Execute stage top level
`timescale 1ns/1ps
`include "ncpu_config.svh"

module ex
(
   input logic clk,
   input logic arst_n,
   input logic flush, // Global pipeline flush
   // Issue side
   input logic [`NCPU_IW-1:0] ex_valid,
   input ncpu_pkg::ex_uop_t [`NCPU_IW-1:0] ex_uop,
   output logic [`NCPU_IW-1:0] ex_ready,
   // Write-back side
   output logic [`NCPU_IW-1:0] wb_valid,
   output ncpu_pkg::ex_wb_t [`NCPU_IW-1:0] wb,
   input logic [`NCPU_IW-1:0] wb_ready
);

   genvar i;

   // Lanes share only clock, reset and flush
   generate
      for (i = 0; i < `NCPU_IW; i = i + 1)
      begin : gen_lane
         ex_lane u_lane
         (
            .clk (clk),
            .arst_n (arst_n),
            .flush (flush),
            .ex_valid (ex_valid[i]),
            .uop (ex_uop[i]),
            .wb_ready (wb_ready[i]),
            .ex_ready (ex_ready[i]),
            .wb_valid (wb_valid[i]),
            .wb (wb[i])
         );
      end
   endgenerate

endmodule

// ==== rtl/ex_alu.sv ====
// Integer ALU
`timescale 1ns/1ps
`include "ncpu_config.svh"

module ex_alu
(
   input ncpu_pkg::ex_uop_t uop,
   output ncpu_pkg::data_t result
);
   import ncpu_pkg::*;

   data_t opa; // First operand
   data_t opb; // Second operand after imm select
   logic [4:0] shamt; // Low bits only
   logic sra_fill; // Bit shifted in from the top
   logic [`NCPU_DW:0] sra_ext; // One extra bit holds the fill
   logic lt_s; // Signed less-than
   logic lt_u; // Unsigned less-than

   assign opa = uop.operand1;
   assign opb = uop.use_imm ? uop.imm : uop.operand2; // Immediate forms
   assign shamt = opb[4:0];

   // Fill is forced to zero when ASR is disabled, so sra degrades to srl
   assign sra_fill = (`NCPU_ENABLE_ASR != 0) ? opa[`NCPU_DW-1] : 1'b0;
   assign sra_ext = $unsigned($signed({sra_fill, opa}) >>> shamt);

   assign lt_s = $signed(opa) < $signed(opb);
   assign lt_u = opa < opb;

   always_comb
   begin
      case (uop.alu_opc)
         ALU_ADD: result = opa + opb;
         ALU_SUB: result = opa - opb;
         ALU_AND: result = opa & opb;
         ALU_OR: result = opa | opb;
         ALU_XOR: result = opa ^ opb;
         ALU_SLL: result = opa << shamt;
         ALU_SRL: result = opa >> shamt; // Zero fill
         ALU_SRA: result = sra_ext[`NCPU_DW-1:0]; // Drop the fill bit
         ALU_SLT: result = data_t'(lt_s); // 1 or 0
         ALU_SLTU: result = data_t'(lt_u);
         default: result = '0; // Unused codes
      endcase
   end

endmodule

// ==== rtl/ex_bru.sv ====
// Branch resolution unit
`timescale 1ns/1ps

module ex_bru
(
   input ncpu_pkg::ex_uop_t uop,
   output logic is_br,
   output ncpu_pkg::data_t link,
   output logic fls,
   output ncpu_pkg::data_t fls_tgt
);
   import ncpu_pkg::*;

   logic cmp; // Condition holds
   logic taken; // Resolved direction
   data_t tgt; // Taken target
   logic dir_miss; // Direction differs from prediction
   logic tgt_miss; // Taken but predicted target is wrong

   assign is_br = (uop.bru_opc != BRU_NONE);

   always_comb
   begin
      case (uop.bru_opc)
         BRU_BEQ: cmp = (uop.operand1 == uop.operand2);
         BRU_BNE: cmp = (uop.operand1 != uop.operand2);
         BRU_BLT: cmp = ($signed(uop.operand1) < $signed(uop.operand2));
         BRU_BGE: cmp = ($signed(uop.operand1) >= $signed(uop.operand2));
         default: cmp = 1'b0; // jal handled below
      endcase
   end

   assign taken = is_br & (cmp | (uop.bru_opc == BRU_JAL));

   assign tgt = uop.pc + uop.imm; // PC-relative
   assign link = uop.pc + data_t'(4); // Also the fall-through

   assign dir_miss = (taken != uop.pred_taken);
   assign tgt_miss = taken & (uop.pred_tgt != tgt);

   assign fls = is_br & (dir_miss | tgt_miss); // Redirect fetch
   assign fls_tgt = taken ? tgt : link;

endmodule

// ==== rtl/ex_lane.sv ====
// Single execute pipe
`timescale 1ns/1ps

module ex_lane
(
   input logic clk,
   input logic arst_n,
   input logic flush,
   input logic ex_valid,
   input ncpu_pkg::ex_uop_t uop,
   input logic wb_ready,
   output logic ex_ready,
   output logic wb_valid,
   output ncpu_pkg::ex_wb_t wb
);
   import ncpu_pkg::*;

   logic load; // Accept into the output register
   data_t alu_result;
   logic is_br;
   data_t br_link; // pc + 4
   logic br_fls;
   data_t br_fls_tgt;
   ex_wb_t wb_nxt; // Record assembled this cycle
   ex_wb_t wb_r; // Qualified by wb_valid

   ex_lane_ctrl u_ctrl
   (
      .clk (clk),
      .arst_n (arst_n),
      .flush (flush),
      .ex_valid (ex_valid),
      .wb_ready (wb_ready),
      .ex_ready (ex_ready),
      .wb_valid (wb_valid),
      .load (load)
   );

   ex_alu u_alu
   (
      .uop (uop),
      .result (alu_result)
   );

   ex_bru u_bru
   (
      .uop (uop),
      .is_br (is_br),
      .link (br_link),
      .fls (br_fls),
      .fls_tgt (br_fls_tgt)
   );

   always_comb
   begin
      wb_nxt.rob_id = uop.rob_id;
      wb_nxt.rob_bank = uop.rob_bank;
      wb_nxt.prf_we = uop.prd_we;
      wb_nxt.prf_waddr = uop.prd;
      wb_nxt.prf_wdata = is_br ? br_link : alu_result; // Branches write the link
      wb_nxt.fls = br_fls;
      wb_nxt.fls_tgt = br_fls_tgt;
      wb_nxt.opera = uop.operand1;
      wb_nxt.operb = uop.operand2;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         wb_r <= wb_nxt; // Holds while stalled
      end
   end

   assign wb = wb_r;

endmodule

// ==== rtl/ex_lane_ctrl.sv ====
// Execute lane control FSM
`timescale 1ns/1ps

module ex_lane_ctrl
(
   input logic clk,
   input logic arst_n,
   input logic flush,
   input logic ex_valid,
   input logic wb_ready,
   output logic ex_ready,
   output logic wb_valid,
   output logic load
);
   import ncpu_pkg::*;

   lane_state_e state_r; // Output register holds a record
   lane_state_e state_nxt;
   logic accept; // Issue handshake
   logic consume; // Write-back handshake

   // Full lane can still take a uop when write-back drains it this cycle
   assign ex_ready = ~flush & ((state_r == EMPTY) | wb_ready);
   assign accept = ex_valid & ex_ready; // Never during flush
   assign wb_valid = (state_r == FULL);
   assign consume = wb_valid & wb_ready;
   assign load = accept; // Capture the new record

   always_comb
   begin
      state_nxt = state_r;
      if (flush)
      begin
         state_nxt = EMPTY; // Discard in-flight record
      end
      else if (accept)
      begin
         state_nxt = FULL; // Replaces any consumed record
      end
      else if (consume)
      begin
         state_nxt = EMPTY;
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_r <= EMPTY;
      end
      else
      begin
         state_r <= state_nxt;
      end
   end

endmodule

// ==== rtl/ncpu_config.svh ====
// Execute stage configuration
`ifndef NCPU_CONFIG_SVH
`define NCPU_CONFIG_SVH

// Datapath word width
`define NCPU_DW 32

// Physical register file address width
`define NCPU_PRF_AW 6

// ROB index and bank widths
`define NCPU_ROB_AW 5
`define NCPU_ROB_BW 1

// Issue lanes into the execute stage
`define NCPU_IW 2

// Sign-filling right shift for the sra opcode
`define NCPU_ENABLE_ASR 1

`endif

// ==== rtl/ncpu_pkg.sv ====
// Core shared types
`include "ncpu_config.svh"

package ncpu_pkg;

   typedef logic [`NCPU_DW-1:0] data_t; // Operand, result or byte PC
   typedef logic [`NCPU_PRF_AW-1:0] prf_addr_t; // Physical register
   typedef logic [`NCPU_ROB_AW-1:0] rob_id_t; // ROB slot index
   typedef logic [`NCPU_ROB_BW-1:0] rob_bank_t; // ROB bank select

   typedef logic [3:0] alu_opc_t;
   localparam alu_opc_t ALU_ADD = 4'd0;
   localparam alu_opc_t ALU_SUB = 4'd1;
   localparam alu_opc_t ALU_AND = 4'd2;
   localparam alu_opc_t ALU_OR = 4'd3;
   localparam alu_opc_t ALU_XOR = 4'd4;
   localparam alu_opc_t ALU_SLL = 4'd5;
   localparam alu_opc_t ALU_SRL = 4'd6;
   localparam alu_opc_t ALU_SRA = 4'd7;
   localparam alu_opc_t ALU_SLT = 4'd8;
   localparam alu_opc_t ALU_SLTU = 4'd9;

   typedef logic [2:0] bru_opc_t;
   localparam bru_opc_t BRU_NONE = 3'd0; // Not a branch
   localparam bru_opc_t BRU_BEQ = 3'd1;
   localparam bru_opc_t BRU_BNE = 3'd2;
   localparam bru_opc_t BRU_BLT = 3'd3; // Signed
   localparam bru_opc_t BRU_BGE = 3'd4; // Signed
   localparam bru_opc_t BRU_JAL = 3'd5; // Always taken

   typedef struct packed {
      data_t pc;
      data_t operand1;
      data_t operand2;
      data_t imm;
      logic use_imm; // imm replaces operand2 in the ALU
      alu_opc_t alu_opc;
      bru_opc_t bru_opc;
      logic pred_taken; // Predictor direction
      data_t pred_tgt; // Predictor target
      prf_addr_t prd; // Destination register
      logic prd_we;
      rob_id_t rob_id;
      rob_bank_t rob_bank;
   } ex_uop_t;

   typedef struct packed {
      rob_id_t rob_id;
      rob_bank_t rob_bank;
      logic prf_we;
      prf_addr_t prf_waddr;
      data_t prf_wdata;
      logic fls; // Mispredict redirect
      data_t fls_tgt; // Correct next PC
      data_t opera; // Branch operands for the ROB
      data_t operb;
   } ex_wb_t;

   typedef enum logic {EMPTY, FULL} lane_state_e;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module ex_tb -o ex_sim

./obj_dir/ex_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
   exit 0
else
   exit 1
fi
